// File: verification/video_stim.txt
# W addr data | E addr data (pslverr expected) | R addr data err | F | P x y rgb | T name
# addr, data and rgb in hex; x, y and err in decimal
F
T frame_geometry
W 000 00000001
W 004 00000002
W 024 00000003
W 0fc 00000004
W 220 76543210
W 24c 11115555
W 260 22222222
W 298 000c0000
W 500 000000f0
W 504 00000123
W 508 000002a4
W 50c 000003c5
W 514 000005e7
W 518 000006d8
W 51c 000009b1
W 530 00000c0f
F
P 1 0 123
P 3 0 3c5
P 10 3 5e7
P 14 3 123
P 9 8 2a4
P 0 0 0f0
T tile_render
W 600 00003e3c
R 600 00003e3c 0
F
P 0 0 c0f
P 4 2 0f0
P 7 2 3c5
P 13 5 5e7
T scroll_wrap
W 600 00000000
W 400 01070808
W 404 01060a0c
W 408 00060000
F
P 9 9 9b1
P 13 11 9b1
P 17 12 6d8
P 1 0 123
P 10 3 5e7
T sprite_priority
W 514 000000ab
F
P 10 3 0ab
P 13 3 123
P 13 11 9b1
P 0 0 0f0
T palette_update
E 100 00000005
R 500 00000000 1
F
P 10 3 0ab
P 0 0 0f0
P 1 0 123
P 13 11 9b1
P 9 8 9b1
T bus_errors

// File: filelist.f
logic/video_pkg.sv
logic/vid_pos_if.sv
logic/vid_wr_if.sv
logic/video_timer.sv
logic/apb_video_port.sv
logic/tile_layer.sv
logic/obj_layer.sv
logic/color_mixer.sv
logic/video_top.sv
verification/video_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= video_tb
RTL_TOP    ?= video_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert --timescale 1ns/100ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/video_tb.sv
`timescale 1ns/100ps

module video_tb;

    localparam int SLOT_LIMIT  = 8;
    localparam int APB_LIMIT   = 16;
    localparam int FRAME_LIMIT = 2 * video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    // Last blank slot index between two visible lines
    localparam int GAP_LAST    = video_pkg::H_TOTAL - video_pkg::H_ACTIVE - 1;
    localparam int HS_OFFSET   = video_pkg::HS_START - video_pkg::H_ACTIVE;

    logic                         clk;
    logic                         rst;
    logic                         pxl_cen;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [video_pkg::APB_AW-1:0] paddr;
    logic [video_pkg::DATA_W-1:0] pwdata;
    logic [video_pkg::DATA_W-1:0] prdata;
    logic                         pready;
    logic                         pslverr;
    logic [3:0]                   red, green, blue;
    logic                         hs;
    logic                         vs;
    logic                         de;

    // Outputs as seen in the middle of a pixel slot
    logic        s_de;
    logic        s_hs;
    logic        s_vs;
    logic [11:0] s_rgb;
    logic [11:0] frame [video_pkg::V_ACTIVE][video_pkg::H_ACTIVE];

    int errors;
    int tests_run;
    int tests_failed;
    int test_start;
    bit aborted;

    video_top video_top_i (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .paddr   ( paddr   ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .pslverr ( pslverr ),
        .red     ( red     ),
        .green   ( green   ),
        .blue    ( blue    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .de      ( de      )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Pixel enable on every second clock
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(negedge clk);
            pxl_cen <= ~pxl_cen;
        end
    end

    task automatic note_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic abort_run(input string msg);
        $display("run stopped at %0t: %s", $time, msg);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            abort_run("malformed command in the stimulus file");
        end
    endtask

    task automatic next_slot();
        int n;
        n = 0;
        @(posedge clk);
        while (!pxl_cen && n < SLOT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!pxl_cen) begin
            abort_run("timeout, pxl_cen stopped pulsing");
        end
        // Registered outputs settle half a clock later
        @(negedge clk);
        s_de  = de;
        s_hs  = hs;
        s_vs  = vs;
        s_rgb = {red, green, blue};
    endtask

    task automatic apb_xfer(input logic is_write, input logic [11:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata,
                            output logic err);
        int n;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        @(posedge clk);
        while (!pready && n < APB_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!pready) begin
            abort_run("timeout, pready never came during an APB access");
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic capture_frame();
        int   n;
        int   row;
        int   col;
        int   since_de;
        int   hs_seen;
        logic prev_vs;
        logic prev_de;
        logic prev_hs;
        foreach (frame[y, x]) begin
            frame[y][x] = 'x;
        end
        // Align to a rising vs
        next_slot();
        n = 0;
        do begin
            prev_vs = s_vs;
            next_slot();
            n++;
        end while (!(s_vs && !prev_vs) && n < FRAME_LIMIT && !aborted);
        if (aborted) begin
            return;
        end
        if (!(s_vs && !prev_vs)) begin
            abort_run("timeout while waiting for the start of a frame");
            return;
        end
        row      = 0;
        col      = 0;
        since_de = FRAME_LIMIT;
        hs_seen  = 0;
        prev_de  = 1'b0;
        prev_hs  = s_hs;
        n        = 0;
        do begin
            prev_vs = s_vs;
            next_slot();
            n++;
            if (s_de) begin
                if (!prev_de && row > 0) begin
                    assert (since_de == GAP_LAST)
                    else note_mismatch($sformatf("blank gap before line %0d is %0d slots",
                                                 row, since_de + 1));
                end
                if (row < video_pkg::V_ACTIVE && col < video_pkg::H_ACTIVE)
                    frame[row][col] = s_rgb;
                col++;
            end else begin
                assert (s_rgb == '0)
                else note_mismatch($sformatf("rgb %03h while de is low", s_rgb));
                if (prev_de) begin
                    assert (col == video_pkg::H_ACTIVE)
                    else note_mismatch($sformatf("line %0d has %0d de pixels", row, col));
                    row++;
                    col      = 0;
                    since_de = 0;
                end else begin
                    since_de++;
                end
            end
            // Sync offset only counts inside a line gap
            if (s_hs && !prev_hs && since_de < video_pkg::H_TOTAL) begin
                hs_seen++;
                assert (since_de == HS_OFFSET)
                else note_mismatch($sformatf("hs rose %0d slots after de fell", since_de));
            end
            prev_de = s_de;
            prev_hs = s_hs;
        end while (!(s_vs && !prev_vs) && n < FRAME_LIMIT && !aborted);
        if (aborted) begin
            return;
        end
        if (!(s_vs && !prev_vs)) begin
            abort_run("timeout while waiting for the end of a frame");
            return;
        end
        assert (row == video_pkg::V_ACTIVE)
        else note_mismatch($sformatf("frame has %0d visible lines", row));
        // One hs pulse in the gap after every visible line
        assert (hs_seen == video_pkg::V_ACTIVE)
        else note_mismatch($sformatf("frame has %0d hs pulses after visible lines", hs_seen));
    endtask

    task automatic check_pixel(input int x, input int y, input logic [11:0] exp_rgb);
        if (x < 0 || x >= video_pkg::H_ACTIVE || y < 0 || y >= video_pkg::V_ACTIVE) begin
            abort_run($sformatf("pixel (%0d,%0d) lies outside the visible area", x, y));
        end else begin
            assert (frame[y][x] === exp_rgb)
            else note_mismatch($sformatf("pixel (%0d,%0d) is %03h, expected %03h",
                                         x, y, frame[y][x], exp_rgb));
        end
    endtask

    task automatic close_test(input logic [8*32-1:0] name);
        int n;
        n = errors - test_start;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %0s: %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
        test_start = errors;
    endtask

    initial begin
        int               fd;
        int               r;
        int               px;
        int               py;
        int               exp_err;
        logic [7:0]       cmd;
        logic [8*32-1:0]  name;
        logic [8*128-1:0] rest;
        logic [11:0]      addr;
        logic [31:0]      data;
        logic [31:0]      rdata;
        logic [11:0]      exp_rgb;
        logic             err;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_start   = 0;
        aborted      = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verification/video_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/video_stim.txt");
        end
        while (!aborted) begin
            r = $fscanf(fd, "%s", cmd);
            if (r != 1) begin
                break;
            end
            case (cmd)
                "#": r = $fgets(rest, fd);
                "W", "E": begin
                    r = $fscanf(fd, "%h %h", addr, data);
                    check_fields(r, 2);
                    if (!aborted) begin
                        apb_xfer(1'b1, addr, data, rdata, err);
                        assert (err == (cmd == "E"))
                        else note_mismatch($sformatf("write %03h gave pslverr %0b", addr, err));
                    end
                end
                "R": begin
                    r = $fscanf(fd, "%h %h %d", addr, data, exp_err);
                    check_fields(r, 3);
                    if (!aborted) begin
                        apb_xfer(1'b0, addr, '0, rdata, err);
                        assert (rdata === data && err === exp_err[0])
                        else note_mismatch($sformatf("read %03h gave %08h err %0b", addr,
                                                     rdata, err));
                    end
                end
                "F": capture_frame();
                "P": begin
                    r = $fscanf(fd, "%d %d %h", px, py, exp_rgb);
                    check_fields(r, 3);
                    if (!aborted) begin
                        check_pixel(px, py, exp_rgb);
                    end
                end
                "T": begin
                    r = $fscanf(fd, "%s", name);
                    check_fields(r, 1);
                    close_test(name);
                end
                default: abort_run("unknown command in the stimulus file");
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !aborted && tests_run > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: logic/video_top.sv
`timescale 1ns/100ps

module video_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    // APB slave
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [video_pkg::APB_AW-1:0]  paddr,
    input  logic [video_pkg::DATA_W-1:0]  pwdata,
    output logic [video_pkg::DATA_W-1:0]  prdata,
    output logic                          pready,
    output logic                          pslverr,
    // Video out
    output logic [video_pkg::COLOR_W-1:0] red,
    output logic [video_pkg::COLOR_W-1:0] green,
    output logic [video_pkg::COLOR_W-1:0] blue,
    output logic                          hs,
    output logic                          vs,
    output logic                          de
);

    logic [video_pkg::SCR_W-1:0] scroll_x, scroll_y;
    logic [video_pkg::PXL_W-1:0] tile_pxl, obj_pxl;

    vid_pos_if pos_bus ();
    vid_wr_if  wr_bus ();

    video_timer u_vtimer (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .pxl_cen ( pxl_cen  ),
        .pos     ( pos_bus  )
    );

    apb_video_port u_apb (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pwrite   ( pwrite   ),
        .paddr    ( paddr    ),
        .pwdata   ( pwdata   ),
        .prdata   ( prdata   ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  ),
        .wr       ( wr_bus   ),
        .scroll_x ( scroll_x ),
        .scroll_y ( scroll_y )
    );

    tile_layer u_tile (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos_bus  ),
        .wr       ( wr_bus   ),
        .scroll_x ( scroll_x ),
        .scroll_y ( scroll_y ),
        .tile_pxl ( tile_pxl )
    );

    obj_layer u_obj (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos_bus  ),
        .wr       ( wr_bus   ),
        .obj_pxl  ( obj_pxl  )
    );

    color_mixer u_colmix (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos_bus  ),
        .wr       ( wr_bus   ),
        .tile_pxl ( tile_pxl ),
        .obj_pxl  ( obj_pxl  ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .de       ( de       )
    );

endmodule

// File: logic/color_mixer.sv
`timescale 1ns/100ps

module color_mixer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    vid_pos_if.snk                        pos,
    vid_wr_if.tgt                         wr,
    input  logic [video_pkg::PXL_W-1:0]   tile_pxl,
    input  logic [video_pkg::PXL_W-1:0]   obj_pxl,
    output logic [video_pkg::COLOR_W-1:0] red,
    output logic [video_pkg::COLOR_W-1:0] green,
    output logic [video_pkg::COLOR_W-1:0] blue,
    output logic                          hs,
    output logic                          vs,
    output logic                          de
);

    logic [video_pkg::RGB_W-1:0]      pal_ram [video_pkg::PAL_WORDS];
    logic [video_pkg::PXL_W-1:0]      sel;
    logic [video_pkg::RGB_W-1:0]      rgb;
    logic [video_pkg::PIPE_DEPTH-1:0] act_sr;
    logic [video_pkg::PIPE_DEPTH-1:0] hs_sr;
    logic [video_pkg::PIPE_DEPTH-1:0] vs_sr;

    always_ff @(posedge clk) begin
        if (wr.pal_we) begin
            pal_ram[wr.idx[video_pkg::PXL_W-1:0]] <= wr.wdata[video_pkg::RGB_W-1:0];
        end
    end

    // Sprite over tiles, zero is transparent
    assign sel = (obj_pxl != '0) ? obj_pxl : tile_pxl;

    always_ff @(posedge clk) begin
        if (rst) begin
            act_sr <= '0;
            hs_sr  <= '0;
            vs_sr  <= '0;
            rgb    <= '0;
        end else if (pxl_cen) begin
            act_sr <= {act_sr[video_pkg::PIPE_DEPTH-2:0], pos.active};
            hs_sr  <= {hs_sr[video_pkg::PIPE_DEPTH-2:0], pos.hs};
            vs_sr  <= {vs_sr[video_pkg::PIPE_DEPTH-2:0], pos.vs};
            // Layer pixels arrive with the second tap
            rgb <= act_sr[video_pkg::PIPE_DEPTH-2] ? pal_ram[sel] : '0;
        end
    end

    assign red   = rgb[11:8];
    assign green = rgb[7:4];
    assign blue  = rgb[3:0];
    assign de    = act_sr[video_pkg::PIPE_DEPTH-1];
    assign hs    = hs_sr[video_pkg::PIPE_DEPTH-1];
    assign vs    = vs_sr[video_pkg::PIPE_DEPTH-1];

endmodule

// File: logic/obj_layer.sv
`timescale 1ns/100ps

module obj_layer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    vid_pos_if.snk                       pos,
    vid_wr_if.tgt                        wr,
    output logic [video_pkg::PXL_W-1:0]  obj_pxl
);

    // Sprite table fields
    logic [7:0]                   obj_x   [video_pkg::NUM_OBJ];
    logic [7:0]                   obj_y   [video_pkg::NUM_OBJ];
    logic [video_pkg::PXL_W-1:0]  obj_col [video_pkg::NUM_OBJ];
    logic [video_pkg::NUM_OBJ-1:0] obj_en;

    logic [8:0]                   px;
    logic [8:0]                   py;
    logic [video_pkg::PXL_W-1:0]  hit_pxl;
    logic [video_pkg::PXL_W-1:0]  s1_pxl;

    always_ff @(posedge clk) begin
        if (wr.obj_we) begin
            obj_x[wr.idx[video_pkg::OBJ_AW-1:0]]   <= wr.wdata[7:0];
            obj_y[wr.idx[video_pkg::OBJ_AW-1:0]]   <= wr.wdata[15:8];
            obj_col[wr.idx[video_pkg::OBJ_AW-1:0]] <= wr.wdata[19:16];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            obj_en <= '0;
        end else if (wr.obj_we) begin
            obj_en[wr.idx[video_pkg::OBJ_AW-1:0]] <= wr.wdata[24];
        end
    end

    // Nine bits so x+7 never wraps
    assign px = 9'(pos.hcnt);
    assign py = 9'(pos.vcnt);

    // Walk from the top index down, lowest index wins
    always_comb begin
        hit_pxl = '0;
        for (int i = video_pkg::NUM_OBJ - 1; i >= 0; i--) begin
            if (obj_en[i] &&
                px >= 9'(obj_x[i]) && px < 9'(obj_x[i]) + 9'(video_pkg::TILE_PX) &&
                py >= 9'(obj_y[i]) && py < 9'(obj_y[i]) + 9'(video_pkg::TILE_PX)) begin
                hit_pxl = obj_col[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_pxl  <= '0;
            obj_pxl <= '0;
        end else if (pxl_cen) begin
            s1_pxl <= hit_pxl;
            // Extra stage to match the tile layer
            obj_pxl <= s1_pxl;
        end
    end

endmodule

// File: logic/tile_layer.sv
`timescale 1ns/100ps

module tile_layer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    vid_pos_if.snk                       pos,
    vid_wr_if.tgt                        wr,
    input  logic [video_pkg::SCR_W-1:0]  scroll_x,
    input  logic [video_pkg::SCR_W-1:0]  scroll_y,
    output logic [video_pkg::PXL_W-1:0]  tile_pxl
);

    logic [video_pkg::CODE_W-1:0] map_ram [video_pkg::MAP_WORDS];
    logic [video_pkg::DATA_W-1:0] pat_ram [video_pkg::PAT_WORDS];

    logic [video_pkg::SCR_W-1:0]  sx;
    logic [video_pkg::SCR_W-1:0]  sy;
    logic [video_pkg::MAP_AW-1:0] map_addr;
    logic [video_pkg::CODE_W-1:0] code_q;
    logic [video_pkg::FINE_W-1:0] row_q;
    logic [video_pkg::FINE_W-1:0] col_q;
    logic [video_pkg::DATA_W-1:0] pat_row;

    // CPU writes land regardless of pxl_cen
    always_ff @(posedge clk) begin
        if (wr.map_we) begin
            map_ram[wr.idx[video_pkg::MAP_AW-1:0]] <= wr.wdata[video_pkg::CODE_W-1:0];
        end
        if (wr.pat_we) begin
            pat_ram[wr.idx[video_pkg::PAT_AW-1:0]] <= wr.wdata;
        end
    end

    // Scrolled position, wraps over the 64x64 map
    assign sx = pos.hcnt[video_pkg::SCR_W-1:0] + scroll_x;
    assign sy = pos.vcnt[video_pkg::SCR_W-1:0] + scroll_y;

    // Map entry is row * 8 + column
    assign map_addr = {sy[video_pkg::SCR_W-1:video_pkg::FINE_W],
                       sx[video_pkg::SCR_W-1:video_pkg::FINE_W]};

    assign pat_row = pat_ram[{code_q, row_q}];

    always_ff @(posedge clk) begin
        if (rst) begin
            code_q   <= '0;
            row_q    <= '0;
            col_q    <= '0;
            tile_pxl <= '0;
        end else if (pxl_cen) begin
            // Stage one: tile code and fine offsets
            code_q <= map_ram[map_addr];
            row_q  <= sy[video_pkg::FINE_W-1:0];
            col_q  <= sx[video_pkg::FINE_W-1:0];
            // Stage two: nibble c is column c
            tile_pxl <= pat_row[col_q * video_pkg::PXL_W +: video_pkg::PXL_W];
        end
    end

endmodule

// File: logic/apb_video_port.sv
`timescale 1ns/100ps

module apb_video_port (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [video_pkg::APB_AW-1:0]  paddr,
    input  logic [video_pkg::DATA_W-1:0]  pwdata,
    output logic [video_pkg::DATA_W-1:0]  prdata,
    output logic                          pready,
    output logic                          pslverr,
    vid_wr_if.cpu                         wr,
    output logic [video_pkg::SCR_W-1:0]   scroll_x,
    output logic [video_pkg::SCR_W-1:0]   scroll_y
);

    logic                         hit_map, hit_pat, hit_obj, hit_pal, hit_scroll;
    logic                         unmapped;
    logic                         xfer;
    logic                         wr_ok;
    logic [video_pkg::APB_AW-1:0] base;
    logic [video_pkg::APB_AW-1:0] offset;

    function automatic logic in_region(input logic [video_pkg::APB_AW-1:0] a,
                                       input int base_addr, input int words);
        int addr_i;
        addr_i = int'(a);
        return (addr_i >= base_addr) && (addr_i < base_addr + 4 * words);
    endfunction

    always_comb begin
        hit_map    = in_region(paddr, video_pkg::ADDR_MAP, video_pkg::MAP_WORDS);
        hit_pat    = in_region(paddr, video_pkg::ADDR_PAT, video_pkg::PAT_WORDS);
        hit_obj    = in_region(paddr, video_pkg::ADDR_OBJ, video_pkg::NUM_OBJ);
        hit_pal    = in_region(paddr, video_pkg::ADDR_PAL, video_pkg::PAL_WORDS);
        hit_scroll = in_region(paddr, video_pkg::ADDR_SCROLL, 1);
        unmapped   = !(hit_map || hit_pat || hit_obj || hit_pal || hit_scroll);
        // Region base for the word index
        base = video_pkg::APB_AW'(video_pkg::ADDR_MAP);
        if (hit_pat) base = video_pkg::APB_AW'(video_pkg::ADDR_PAT);
        if (hit_obj) base = video_pkg::APB_AW'(video_pkg::ADDR_OBJ);
        if (hit_pal) base = video_pkg::APB_AW'(video_pkg::ADDR_PAL);
    end

    // Zero wait states, the access phase always completes
    assign pready = psel && penable;
    assign xfer   = pready;
    assign wr_ok  = xfer && pwrite && !unmapped;

    assign offset    = paddr - base;
    assign wr.idx    = offset[video_pkg::IDX_W+1:2];
    assign wr.wdata  = pwdata;
    assign wr.map_we = wr_ok && hit_map;
    assign wr.pat_we = wr_ok && hit_pat;
    assign wr.obj_we = wr_ok && hit_obj;
    assign wr.pal_we = wr_ok && hit_pal;

    always_ff @(posedge clk) begin
        if (rst) begin
            scroll_x <= '0;
            scroll_y <= '0;
        end else if (wr_ok && hit_scroll) begin
            scroll_x <= pwdata[video_pkg::SCR_W-1:0];
            scroll_y <= pwdata[8 +: video_pkg::SCR_W];
        end
    end

    // Only the scroll register reads back
    assign pslverr = xfer && (unmapped || (!pwrite && !hit_scroll));
    assign prdata  = (xfer && !pwrite && hit_scroll) ?
                     {18'd0, scroll_y, 2'd0, scroll_x} : '0;

endmodule

// File: logic/video_timer.sv
`timescale 1ns/100ps

module video_timer (
    input  logic      clk,
    input  logic      rst,
    input  logic      pxl_cen,
    vid_pos_if.src    pos
);

    logic [video_pkg::CNT_W-1:0] hcnt;
    logic [video_pkg::CNT_W-1:0] vcnt;
    logic                        h_last;
    logic                        v_last;

    assign h_last = hcnt == video_pkg::CNT_W'(video_pkg::H_TOTAL - 1);
    assign v_last = vcnt == video_pkg::CNT_W'(video_pkg::V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hcnt <= '0;
                // Line advances on the horizontal wrap
                vcnt <= v_last ? '0 : vcnt + 1'b1;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    assign pos.hcnt = hcnt;
    assign pos.vcnt = vcnt;

    assign pos.active = (hcnt < video_pkg::CNT_W'(video_pkg::H_ACTIVE)) &&
                        (vcnt < video_pkg::CNT_W'(video_pkg::V_ACTIVE));

    // Sync windows, end value excluded
    assign pos.hs = (hcnt >= video_pkg::CNT_W'(video_pkg::HS_START)) &&
                    (hcnt <  video_pkg::CNT_W'(video_pkg::HS_END));
    assign pos.vs = (vcnt >= video_pkg::CNT_W'(video_pkg::VS_START)) &&
                    (vcnt <  video_pkg::CNT_W'(video_pkg::VS_END));

endmodule

// File: logic/vid_wr_if.sv
`timescale 1ns/100ps

interface vid_wr_if;

    // One strobe per RAM, never two at once
    logic                         map_we;
    logic                         pat_we;
    logic                         obj_we;
    logic                         pal_we;
    logic [video_pkg::IDX_W-1:0]  idx;
    logic [video_pkg::DATA_W-1:0] wdata;

    modport cpu (output map_we, pat_we, obj_we, pal_we, idx, wdata);

    modport tgt (input map_we, pat_we, obj_we, pal_we, idx, wdata);

endinterface

// File: logic/vid_pos_if.sv
`timescale 1ns/100ps

interface vid_pos_if;

    logic [video_pkg::CNT_W-1:0] hcnt;
    logic [video_pkg::CNT_W-1:0] vcnt;
    logic                        active;
    logic                        hs;
    logic                        vs;

    // Timer side
    modport src (output hcnt, vcnt, active, hs, vs);

    // Layers and mixer follow the position
    modport snk (input hcnt, vcnt, active, hs, vs);

endinterface

// File: logic/video_pkg.sv
package video_pkg;

    // Raster geometry, kept small for short simulations
    localparam int H_TOTAL  = 64;
    localparam int H_ACTIVE = 48;
    localparam int HS_START = 52;
    localparam int HS_END   = 56;
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;
    localparam int VS_START = 35;
    localparam int VS_END   = 37;
    localparam int CNT_W    = 7;

    // Tiles and sprites
    localparam int TILE_PX   = 8;
    localparam int FINE_W    = $clog2(TILE_PX);
    localparam int MAP_TILES = 8;
    localparam int MAP_WORDS = MAP_TILES * MAP_TILES;
    localparam int MAP_AW    = $clog2(MAP_WORDS);
    localparam int PAT_WORDS = 128;
    localparam int PAT_AW    = $clog2(PAT_WORDS);
    localparam int NUM_OBJ   = 8;
    localparam int OBJ_AW    = $clog2(NUM_OBJ);
    localparam int CODE_W    = 4;

    // Pixel, palette and colour widths
    localparam int PXL_W     = 4;
    localparam int PAL_WORDS = 1 << PXL_W;
    localparam int COLOR_W   = 4;
    localparam int RGB_W     = 3 * COLOR_W;

    // Scroll wraps over the 64x64 map
    localparam int SCR_W = 6;

    // CPU bus and address map, byte addresses
    localparam int APB_AW      = 12;
    localparam int DATA_W      = 32;
    localparam int IDX_W       = PAT_AW;
    localparam int ADDR_MAP    = 'h000;
    localparam int ADDR_PAT    = 'h200;
    localparam int ADDR_OBJ    = 'h400;
    localparam int ADDR_PAL    = 'h500;
    localparam int ADDR_SCROLL = 'h600;

    // Ticks from counter position to output pixel
    localparam int PIPE_DEPTH = 3;

endpackage
